// File: hdl/cpuPkg.sv
package cpuPkg;

  //////////////////////////////////////////////////
  // Widths and constants
  //////////////////////////////////////////////////
  localparam int addrWidth = 16;                           // PC and Rs width
  localparam int immWidth  = 9;                            // Branch offset in halfwords
  localparam logic [addrWidth-1:0] resetPc     = 16'h0000; // PC after reset
  localparam logic [addrWidth-1:0] pcIncrement = 16'h0002; // One instruction is 2 bytes

  //////////////////////////////////////////////////
  // Flags, opcodes and condition codes
  //////////////////////////////////////////////////
  typedef struct packed {
    logic z;  // Zero
    logic v;  // Overflow
    logic n;  // Negative
  } flags_t;

  typedef enum logic [2:0] {
    opArith,      // Add/sub class, writes Z, V and N
    opLogic,      // Writes Z only
    opBranch,     // B, PC-relative
    opBranchReg,  // BR, target from Rs
    opOther       // No flags, no branch
  } opcode_t;

  // Encoding matches the ccc field of the branch instructions
  typedef enum logic [2:0] {
    condNe     = 3'b000,
    condEq     = 3'b001,
    condGt     = 3'b010,
    condLt     = 3'b011,
    condGe     = 3'b100,
    condLe     = 3'b101,
    condOv     = 3'b110,
    condAlways = 3'b111
  } cond_t;

  //////////////////////////////////////////////////
  // Command and result payloads
  //////////////////////////////////////////////////
  typedef struct packed {
    opcode_t               opcode;
    cond_t                 cond;
    logic [immWidth-1:0]   imm;       // Signed offset in halfwords
    logic [addrWidth-1:0]  rs;        // BR target
    flags_t                aluFlags;  // Flags produced by the ALU for this instruction
  } pcCmd_t;

  typedef struct packed {
    logic [addrWidth-1:0]  pc;     // Address of the next instruction
    logic                  taken;  // Taken B or BR
    flags_t                flags;  // Flags after the command
  } pcResult_t;

  // Flag update rule, shared by the flag register and the result path
  function automatic flags_t nextFlags(opcode_t opcode, flags_t current, flags_t alu);
    flags_t updated;
    updated = current;
    case (opcode)
      opArith: updated = alu;        // All three flags
      opLogic: updated.z = alu.z;    // Z only
      default: updated = current;    // Branches and others hold
    endcase
    return updated;
  endfunction

endpackage

// File: hdl/cla4.sv
`default_nettype none
`timescale 1ns/1ps

module cla4 (
  input  logic [3:0] a,
  input  logic [3:0] b,
  input  logic       cin,
  output logic [3:0] sum,
  output logic       groupP,  // Block propagates a carry
  output logic       groupG   // Block generates a carry
);

  logic [3:0] p;  // Bit propagate
  logic [3:0] g;  // Bit generate
  logic [3:0] c;  // Carry into each bit

  assign p = a ^ b;
  assign g = a & b;

  //////////////////////////////////////////////////
  // Lookahead carries
  //////////////////////////////////////////////////
  assign c[0] = cin;
  assign c[1] = g[0] | (p[0] & cin);
  assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
  assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
              | (p[2] & p[1] & p[0] & cin);

  assign sum = p ^ c;  // Half-sum with carry in

  // Group terms for the second level
  assign groupP = &p;
  assign groupG = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                | (p[3] & p[2] & p[1] & g[0]);

endmodule

`default_nettype wire

// File: hdl/cla16.sv
`default_nettype none
`timescale 1ns/1ps

module cla16 (
  input  logic [15:0] a,
  input  logic [15:0] b,
  output logic [15:0] sum
);

  logic [2:0] blkP;   // Group propagate, blocks 0..2
  logic [2:0] blkG;   // Group generate, blocks 0..2
  logic [3:0] blkC;   // Carry into each block

  //////////////////////////////////////////////////
  // Second-level lookahead
  //////////////////////////////////////////////////
  // PC arithmetic wraps, so carry-in is 0 and carry-out is dropped
  assign blkC[0] = 1'b0;
  assign blkC[1] = blkG[0] | (blkP[0] & blkC[0]);
  assign blkC[2] = blkG[1] | (blkP[1] & blkG[0]) | (blkP[1] & blkP[0] & blkC[0]);
  assign blkC[3] = blkG[2] | (blkP[2] & blkG[1]) | (blkP[2] & blkP[1] & blkG[0])
                 | (blkP[2] & blkP[1] & blkP[0] & blkC[0]);

  //////////////////////////////////////////////////
  // Four 4-bit blocks
  //////////////////////////////////////////////////
  cla4 uBlk0 (
    .a(a[3:0]), .b(b[3:0]), .cin(blkC[0]), .sum(sum[3:0]),
    .groupP(blkP[0]), .groupG(blkG[0])
  );

  cla4 uBlk1 (
    .a(a[7:4]), .b(b[7:4]), .cin(blkC[1]), .sum(sum[7:4]),
    .groupP(blkP[1]), .groupG(blkG[1])
  );

  cla4 uBlk2 (
    .a(a[11:8]), .b(b[11:8]), .cin(blkC[2]), .sum(sum[11:8]),
    .groupP(blkP[2]), .groupG(blkG[2])
  );

  // Top block group terms would only feed the carry-out
  cla4 uBlk3 (
    .a(a[15:12]), .b(b[15:12]), .cin(blkC[3]), .sum(sum[15:12]),
    .groupP(), .groupG()
  );

endmodule

`default_nettype wire

// File: hdl/branchCondition.sv
`default_nettype none
`timescale 1ns/1ps

module branchCondition (
  input  cpuPkg::cond_t  cond,
  input  cpuPkg::flags_t flags,
  output logic           taken
);

  //////////////////////////////////////////////////
  // Condition decode against stored Z, V, N
  //////////////////////////////////////////////////
  always_comb begin
    case (cond)
      cpuPkg::condNe:     taken = ~flags.z;                        // Not equal
      cpuPkg::condEq:     taken = flags.z;                         // Equal
      cpuPkg::condGt:     taken = ~flags.z & ~flags.n;             // Greater than
      cpuPkg::condLt:     taken = flags.n;                         // Less than
      cpuPkg::condGe:     taken = flags.z | (~flags.z & ~flags.n); // Greater or equal
      cpuPkg::condLe:     taken = flags.z | flags.n;               // Less or equal
      cpuPkg::condOv:     taken = flags.v;                         // Overflow
      cpuPkg::condAlways: taken = 1'b1;                            // Unconditional
      default:            taken = 1'b0;
    endcase
  end

  // Unconditional code must win whatever the flags hold
  always_comb begin
    if (cond == cpuPkg::condAlways) begin
      assert final (taken)
        else $error("condAlways decoded as not taken, flags %b", flags);
    end
  end

endmodule

`default_nettype wire

// File: hdl/pcControl.sv
`default_nettype none
`timescale 1ns/1ps

module pcControl (
  input  logic [cpuPkg::addrWidth-1:0] pc,
  input  cpuPkg::pcCmd_t               cmd,
  input  cpuPkg::flags_t               flags,
  output logic [cpuPkg::addrWidth-1:0] nextPc,
  output logic                         taken
);

  logic [cpuPkg::addrWidth-1:0] pcPlus2;       // Sequential address
  logic [cpuPkg::addrWidth-1:0] offset;        // Sign-extended imm << 1
  logic [cpuPkg::addrWidth-1:0] branchTarget;  // PC+2 + offset
  logic                         condMet;
  logic                         isBranch;
  logic                         isBranchReg;

  //////////////////////////////////////////////////
  // Adders
  //////////////////////////////////////////////////
  assign offset = {{(cpuPkg::addrWidth-cpuPkg::immWidth-1){cmd.imm[cpuPkg::immWidth-1]}},
                   cmd.imm, 1'b0};

  cla16 uSeqAdder (.a(pc), .b(cpuPkg::pcIncrement), .sum(pcPlus2));

  cla16 uBranchAdder (.a(pcPlus2), .b(offset), .sum(branchTarget));  // Relative to PC+2

  //////////////////////////////////////////////////
  // Branch decision and target select
  //////////////////////////////////////////////////
  branchCondition uCond (.cond(cmd.cond), .flags(flags), .taken(condMet));

  assign isBranch    = (cmd.opcode == cpuPkg::opBranch);
  assign isBranchReg = (cmd.opcode == cpuPkg::opBranchReg);
  assign taken       = condMet & (isBranch | isBranchReg);  // Only branches can redirect

  always_comb begin
    nextPc = pcPlus2;  // Fall through by default
    if (taken) begin
      nextPc = isBranchReg ? cmd.rs : branchTarget;  // BR jumps to Rs
    end
  end

  // Even offsets keep PC parity, only BR can introduce an odd address
  always_comb begin
    if (!(taken && isBranchReg)) begin
      assert final (nextPc[0] == pc[0])
        else $error("nextPc %h parity differs from pc %h", nextPc, pc);
    end
  end

endmodule

`default_nettype wire

// File: hdl/flagRegister.sv
`default_nettype none
`timescale 1ns/1ps

module flagRegister (
  input  logic             clk,
  input  logic             reset,
  input  logic             write,     // Strobe on command acceptance
  input  cpuPkg::opcode_t  opcode,
  input  cpuPkg::flags_t   aluFlags,
  output cpuPkg::flags_t   flags
);

  cpuPkg::flags_t flagsNext;  // Value after applying the write rule

  //////////////////////////////////////////////////
  // Opcode-dependent update
  //////////////////////////////////////////////////
  // Arith loads Z/V/N, logic loads Z, everything else holds
  assign flagsNext = cpuPkg::nextFlags(opcode, flags, aluFlags);

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;           // Z = V = N = 0
    end else if (write) begin
      flags <= flagsNext;
    end
  end

  // Non-flag-writing opcodes must leave the register untouched
  property pHoldOnNoWrite;
    @(posedge clk) disable iff (reset)
      (write && (opcode != cpuPkg::opArith) && (opcode != cpuPkg::opLogic))
        |=> $stable(flags);
  endproperty

  assert property (pHoldOnNoWrite)
    else $error("flags changed on opcode without flag write");

  // A logic op may only move Z
  property pLogicKeepsVn;
    @(posedge clk) disable iff (reset)
      (write && (opcode == cpuPkg::opLogic)) |=> $stable({flags.v, flags.n});
  endproperty

  assert property (pLogicKeepsVn)
    else $error("logic op changed V or N");

endmodule

`default_nettype wire

// File: hdl/pcUnit.sv
`default_nettype none
`timescale 1ns/1ps

module pcUnit (
  input  logic                clk,
  input  logic                reset,
  // Command stream
  input  logic                cmdValid,
  output logic                cmdReady,
  input  cpuPkg::pcCmd_t      cmd,
  // Result stream
  output logic                resultValid,
  input  logic                resultReady,
  output cpuPkg::pcResult_t   result
);

  logic [cpuPkg::addrWidth-1:0] pcReg;    // Current PC
  logic [cpuPkg::addrWidth-1:0] nextPc;   // From pcControl
  logic                         taken;
  logic                         accept;   // Command handshake this cycle
  cpuPkg::flags_t               flags;    // Stored Z/V/N

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////
  assign cmdReady = !resultValid || resultReady;  // Output slot free or draining
  assign accept   = cmdValid && cmdReady;

  //////////////////////////////////////////////////
  // Next-PC logic and flag state
  //////////////////////////////////////////////////
  pcControl uControl (
    .pc     (pcReg),
    .cmd    (cmd),
    .flags  (flags),
    .nextPc (nextPc),
    .taken  (taken)
  );

  flagRegister uFlagReg (
    .clk      (clk),
    .reset    (reset),
    .write    (accept),
    .opcode   (cmd.opcode),
    .aluFlags (cmd.aluFlags),
    .flags    (flags)
  );

  //////////////////////////////////////////////////
  // PC register
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      pcReg <= cpuPkg::resetPc;
    end else if (accept) begin
      pcReg <= nextPc;       // Same edge as the flag write
    end
  end

  //////////////////////////////////////////////////
  // Output holding register
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      resultValid <= 1'b0;
    end else if (accept) begin
      resultValid <= 1'b1;   // Refill, possibly while draining
    end else if (resultReady) begin
      resultValid <= 1'b0;   // Drained with nothing behind it
    end
  end

  // Payload only, valid bit above qualifies it
  always_ff @(posedge clk) begin
    if (accept) begin
      result.pc    <= nextPc;
      result.taken <= taken;
      result.flags <= cpuPkg::nextFlags(cmd.opcode, flags, cmd.aluFlags);
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  assert property (@(posedge clk) disable iff (reset)
                   (resultValid && !resultReady) |=> (resultValid && $stable(result)))
    else $error("result changed under back-pressure");

  assert property (@(posedge clk) reset |=> !resultValid)
    else $error("resultValid high after reset");

endmodule

`default_nettype wire

// File: verif/pcUnitCases.svh
`ifndef PCUNITCASES_SVH
`define PCUNITCASES_SVH

// Row: opcode, cond, imm (halfwords), rs, aluFlags {z,v,n},
//      expected pc, expected taken, expected flags {z,v,n}

typedef struct packed {
  cpuPkg::pcCmd_t               cmd;
  logic [cpuPkg::addrWidth-1:0] pc;     // Next PC
  logic                         taken;  // Taken B or BR
  cpuPkg::flags_t               flags;  // Flags after the command
} caseEntry_t;

caseEntry_t cases[$];  // Applied and checked in order

// Short names keep the rows readable
localparam cpuPkg::opcode_t oArith = cpuPkg::opArith;
localparam cpuPkg::opcode_t oLogic = cpuPkg::opLogic;
localparam cpuPkg::opcode_t oB     = cpuPkg::opBranch;
localparam cpuPkg::opcode_t oBr    = cpuPkg::opBranchReg;
localparam cpuPkg::opcode_t oOther = cpuPkg::opOther;
localparam cpuPkg::cond_t   cNe    = cpuPkg::condNe;
localparam cpuPkg::cond_t   cEq    = cpuPkg::condEq;
localparam cpuPkg::cond_t   cGt    = cpuPkg::condGt;
localparam cpuPkg::cond_t   cLt    = cpuPkg::condLt;
localparam cpuPkg::cond_t   cGe    = cpuPkg::condGe;
localparam cpuPkg::cond_t   cLe    = cpuPkg::condLe;
localparam cpuPkg::cond_t   cOv    = cpuPkg::condOv;
localparam cpuPkg::cond_t   cAl    = cpuPkg::condAlways;

task automatic addCase(input cpuPkg::opcode_t op, input cpuPkg::cond_t cond,
                       input logic [8:0] imm, input logic [15:0] rs, input logic [2:0] alu,
                       input logic [15:0] pc, input logic taken, input logic [2:0] flags);
  caseEntry_t entry;
  entry = {op, cond, imm, rs, alu, pc, taken, flags};  // Field order of caseEntry_t
  cases.push_back(entry);
endtask

task automatic buildCases();
  // Sequential flow and flag write rules
  addCase(oOther, cAl, 9'h000, 16'h0000, 3'b111, 16'h0002, 1'b0, 3'b000);  // No flag write
  addCase(oArith, cNe, 9'h000, 16'h0000, 3'b000, 16'h0004, 1'b0, 3'b000);
  addCase(oArith, cNe, 9'h000, 16'h0000, 3'b100, 16'h0006, 1'b0, 3'b100);
  addCase(oB,     cLe, 9'h1FF, 16'h0000, 3'b000, 16'h0006, 1'b1, 3'b100);  // Z alone, LE
  addCase(oLogic, cAl, 9'h000, 16'h0000, 3'b011, 16'h0008, 1'b0, 3'b000);  // Z only
  addCase(oArith, cNe, 9'h000, 16'h0000, 3'b011, 16'h000A, 1'b0, 3'b011);
  addCase(oLogic, cNe, 9'h000, 16'h0000, 3'b100, 16'h000C, 1'b0, 3'b111);  // V, N kept
  // Conditions with Z, V and N all set
  addCase(oB,     cNe, 9'h010, 16'h0000, 3'b000, 16'h000E, 1'b0, 3'b111);
  addCase(oB,     cEq, 9'h004, 16'h0000, 3'b000, 16'h0018, 1'b1, 3'b111);
  addCase(oB,     cOv, 9'h1FF, 16'h0000, 3'b010, 16'h0018, 1'b1, 3'b111);  // imm -1
  addCase(oB,     cGt, 9'h010, 16'h0000, 3'b000, 16'h001A, 1'b0, 3'b111);
  addCase(oB,     cLt, 9'h002, 16'h0000, 3'b000, 16'h0020, 1'b1, 3'b111);
  addCase(oB,     cGe, 9'h1FF, 16'h0000, 3'b000, 16'h0020, 1'b1, 3'b111);  // Z wins over N
  // Conditions with all flags clear
  addCase(oArith, cNe, 9'h000, 16'h0000, 3'b000, 16'h0022, 1'b0, 3'b000);
  addCase(oB,     cGt, 9'h000, 16'h0000, 3'b111, 16'h0024, 1'b1, 3'b000);
  addCase(oB,     cGe, 9'h001, 16'h0000, 3'b000, 16'h0028, 1'b1, 3'b000);
  addCase(oB,     cLe, 9'h010, 16'h0000, 3'b000, 16'h002A, 1'b0, 3'b000);
  addCase(oB,     cOv, 9'h010, 16'h0000, 3'b000, 16'h002C, 1'b0, 3'b000);
  addCase(oB,     cLt, 9'h010, 16'h0000, 3'b000, 16'h002E, 1'b0, 3'b000);
  addCase(oB,     cEq, 9'h010, 16'h0000, 3'b000, 16'h0030, 1'b0, 3'b000);
  addCase(oB,     cNe, 9'h003, 16'h0000, 3'b000, 16'h0038, 1'b1, 3'b000);
  // N alone set
  addCase(oArith, cNe, 9'h000, 16'h0000, 3'b001, 16'h003A, 1'b0, 3'b001);
  addCase(oB,     cGe, 9'h010, 16'h0000, 3'b000, 16'h003C, 1'b0, 3'b001);
  addCase(oB,     cLe, 9'h008, 16'h0000, 3'b000, 16'h004E, 1'b1, 3'b001);
  // BR to an odd Rs, then straight-line from there
  addCase(oBr,    cAl, 9'h000, 16'h1235, 3'b110, 16'h1235, 1'b1, 3'b001);
  addCase(oOther, cAl, 9'h000, 16'h0000, 3'b111, 16'h1237, 1'b0, 3'b001);
  addCase(oBr,    cEq, 9'h000, 16'hABCD, 3'b000, 16'h1239, 1'b0, 3'b001);  // Not taken
  // Offset extremes and wraparound
  addCase(oB,     cAl, 9'h100, 16'h0000, 3'b000, 16'h103B, 1'b1, 3'b001);  // -256
  addCase(oB,     cAl, 9'h0FF, 16'h0000, 3'b000, 16'h123B, 1'b1, 3'b001);  // +255
  addCase(oBr,    cAl, 9'h000, 16'h0010, 3'b000, 16'h0010, 1'b1, 3'b001);
  addCase(oB,     cAl, 9'h1F0, 16'h0000, 3'b000, 16'hFFF2, 1'b1, 3'b001);  // Below 0
  addCase(oBr,    cAl, 9'h000, 16'hFFF0, 3'b000, 16'hFFF0, 1'b1, 3'b001);
  addCase(oB,     cAl, 9'h020, 16'h0000, 3'b000, 16'h0032, 1'b1, 3'b001);  // Past FFFE
  addCase(oBr,    cAl, 9'h000, 16'hFFFE, 3'b000, 16'hFFFE, 1'b1, 3'b001);
  addCase(oOther, cNe, 9'h000, 16'h0000, 3'b000, 16'h0000, 1'b0, 3'b001);  // PC+2 wraps
  addCase(oArith, cNe, 9'h000, 16'h0000, 3'b110, 16'h0002, 1'b0, 3'b110);
  addCase(oB,     cOv, 9'h1FE, 16'h0000, 3'b000, 16'h0000, 1'b1, 3'b110);
endtask

`endif

// File: verif/tbPcUnit.sv
`timescale 1ns/1ps

module tbPcUnit;

  logic              clk = 1'b0;
  logic              reset;
  logic              cmdValid;
  logic              cmdReady;
  cpuPkg::pcCmd_t    cmd;
  logic              resultValid;
  logic              resultReady = 1'b0;  // Owned by the back-pressure process
  cpuPkg::pcResult_t result;

  integer seed   = 32'hc9ea_6f68;  // $random state
  int     cycles = 0;              // Rising edges so far
  int     resIdx = 0;              // Next table entry to compare against
  int     timeoutLimit;            // 20 cycles per entry plus 50

  `include "pcUnitCases.svh"

  pcUnit u_dut (.*);  // Port names match the testbench signals

  always #50 clk = ~clk;  // 100 ns period

  //////////////////////////////////////////////////
  // Error reporting and compares
  //////////////////////////////////////////////////
  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic checkPc(input int idx, input logic [cpuPkg::addrWidth-1:0] got, expected);
    if (got !== expected) begin
      abortRun($sformatf("ERR result.pc entry %0d got %h expected %h", idx, got, expected));
    end
  endtask

  task automatic checkTaken(input int idx, input logic got, expected);
    if (got !== expected) begin
      abortRun($sformatf("ERR result.taken entry %0d got %h expected %h", idx, got, expected));
    end
  endtask

  task automatic checkFlags(input int idx, input cpuPkg::flags_t got, expected);
    if (got !== expected) begin
      abortRun($sformatf("ERR result.flags entry %0d got %h expected %h", idx, got, expected));
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus and result collection
  //////////////////////////////////////////////////
  // Present one command, return 1 ns after the edge that takes it
  task automatic sendCommand(input cpuPkg::pcCmd_t c);
    cmdValid = 1'b1;
    cmd      = c;            // Held while stalled
    @(negedge clk);
    while (!cmdReady) begin
      @(negedge clk);
    end
    @(posedge clk);          // Handshake edge
    #1;
  endtask

  // Back-pressure, low roughly one cycle in four
  always @(posedge clk) begin
    #1;
    resultReady = (($random(seed) & 3) != 0);
  end

  // Sampled at the falling edge where the result is stable
  // A transfer seen here completes on the next rising edge
  always @(negedge clk) begin
    if (!reset && resultValid && resultReady) begin
      if (resIdx >= cases.size()) begin
        abortRun("A result arrived after every table entry was already matched");
      end else begin
        checkPc(resIdx, result.pc, cases[resIdx].pc);
        checkTaken(resIdx, result.taken, cases[resIdx].taken);
        checkFlags(resIdx, result.flags, cases[resIdx].flags);
        resIdx++;
      end
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeoutLimit) begin
      abortRun($sformatf("Run timed out after %0d cycles without finishing the table", cycles));
    end
  end

  initial begin
    reset    = 1'b1;
    cmdValid = 1'b0;
    cmd      = '0;
    buildCases();
    timeoutLimit = cases.size() * 20 + 50;
    repeat (8) @(posedge clk);  // Reset held for 8 cycles
    #1;
    reset = 1'b0;
    foreach (cases[i]) begin
      sendCommand(cases[i].cmd);
    end
    cmdValid = 1'b0;
    wait (resIdx == cases.size());  // Every entry answered
    repeat (4) @(posedge clk);      // Window for a duplicated result
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: pcUnit.f
+incdir+verif
hdl/cpuPkg.sv
hdl/cla4.sv
hdl/cla16.sv
hdl/branchCondition.sv
hdl/pcControl.sv
hdl/flagRegister.sv
hdl/pcUnit.sv
verif/tbPcUnit.sv

// File: run.sh
#!/usr/bin/env bash
# Build the pcUnit testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tbPcUnit -f pcUnit.f -o simPcUnit \
  || { echo "Verilator build failed"; exit 1; }
simOut="$(./obj_dir/simPcUnit 2>&1)"
echo "$simOut"
echo "$simOut" | grep -qx "TEST PASSED" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
